// ==== rtl/net_hdr_pkg.sv ====
// Network header types
package net_hdr_pkg;

    localparam int MAC_WIDTH       = 48;
    localparam int IP_ADDR_WIDTH   = 32;
    localparam int UDP_FIELD_WIDTH = 16;
    localparam int UDP_HDR_BYTES   = 8;

    // IP frame header with the Ethernet fields in front
    typedef struct packed {
        logic [MAC_WIDTH-1:0]     eth_dest_mac;
        logic [MAC_WIDTH-1:0]     eth_src_mac;
        logic [15:0]              eth_type;
        logic [3:0]               version;
        logic [3:0]               ihl;
        logic [5:0]               dscp;
        logic [1:0]               ecn;
        logic [15:0]              length;
        logic [15:0]              identification;
        logic [2:0]               flags;
        logic [12:0]              fragment_offset;
        logic [7:0]               ttl;
        logic [7:0]               protocol;
        logic [15:0]              header_checksum;
        logic [IP_ADDR_WIDTH-1:0] source_ip;
        logic [IP_ADDR_WIDTH-1:0] dest_ip;
    } ip_hdr_t;

    typedef struct packed {
        logic [UDP_FIELD_WIDTH-1:0] source_port;
        logic [UDP_FIELD_WIDTH-1:0] dest_port;
        logic [UDP_FIELD_WIDTH-1:0] length;
        logic [UDP_FIELD_WIDTH-1:0] checksum;
    } udp_hdr_t;

    typedef struct packed {
        ip_hdr_t  ip;
        udp_hdr_t udp;
    } udp_meta_t;

    // First beat in network byte order, wire byte 0 sits in the top byte
    // so that source_port lands first in the struct view
    typedef union packed {
        logic [UDP_HDR_BYTES*8-1:0] data;
        udp_hdr_t                   hdr;
    } udp_first_word_u;

endpackage

// ==== rtl/udp_stream_pkg.sv ====
// Payload stream definitions
package udp_stream_pkg;

    localparam int DATA_BYTES  = 8;
    localparam int DATA_WIDTH  = DATA_BYTES * 8;

    // Wide enough to hold a full-beat byte count
    localparam int COUNT_WIDTH = $clog2(DATA_BYTES) + 1;

    // Keep is contiguous from byte 0
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
        logic                  user;
    } axis_beat_t;

endpackage

// ==== rtl/udp_hdr_capture.sv ====
// UDP header capture stage
module udp_hdr_capture (
    input  logic                                    clk,
    input  logic                                    reset,

    input  logic                                    s_ip_hdr_valid,
    input  net_hdr_pkg::ip_hdr_t                    s_ip_hdr,
    output logic                                    s_ip_hdr_ready,

    input  logic                                    s_ip_payload_valid,
    input  udp_stream_pkg::axis_beat_t              s_ip_payload,
    output logic                                    s_ip_payload_ready,

    output logic                                    m_udp_hdr_valid,
    output net_hdr_pkg::udp_meta_t                  m_udp_hdr,
    input  logic                                    m_udp_hdr_ready,

    output logic                                    frame_start,
    output logic [net_hdr_pkg::UDP_FIELD_WIDTH-1:0] udp_length,
    output logic                                    fwd_valid,
    output udp_stream_pkg::axis_beat_t              fwd_beat,
    input  logic                                    fwd_ready,

    output logic                                    busy,
    output logic                                    error_header_early_termination
);
    import net_hdr_pkg::*;
    import udp_stream_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FIRST,
        ST_FORWARD,
        ST_DROP
    } state_t;

    state_t          state;
    udp_first_word_u first_word;
    logic            hdr_xfer;
    logic            beat_xfer;
    logic            first_full;
    logic            first_bad;

    // New header only after the previous one has left
    assign s_ip_hdr_ready = (state == ST_IDLE) && !m_udp_hdr_valid;
    assign hdr_xfer       = s_ip_hdr_valid && s_ip_hdr_ready;

    always_comb begin
        case (state)
            ST_FIRST:   s_ip_payload_ready = 1'b1;
            ST_FORWARD: s_ip_payload_ready = fwd_ready;
            ST_DROP:    s_ip_payload_ready = 1'b1;
            default:    s_ip_payload_ready = 1'b0;
        endcase
    end

    assign beat_xfer  = s_ip_payload_valid && s_ip_payload_ready;
    assign first_full = s_ip_payload.keep == {DATA_BYTES{1'b1}};

    // Byte swap so the big-endian fields read straight out of the union
    always_comb begin
        first_word.data = {<<8{s_ip_payload.data}};
    end

    assign frame_start = (state == ST_FIRST) && beat_xfer && first_full;
    assign first_bad   = (state == ST_FIRST) && beat_xfer && !first_full;
    assign udp_length  = first_word.hdr.length;

    // Later beats go straight to the trim stage
    assign fwd_valid = (state == ST_FORWARD) && s_ip_payload_valid;
    assign fwd_beat  = s_ip_payload;

    always_ff @(posedge clk) begin
        if (reset) begin
            state                          <= ST_IDLE;
            m_udp_hdr_valid                <= 1'b0;
            busy                           <= 1'b0;
            error_header_early_termination <= 1'b0;
        end else begin
            error_header_early_termination <= first_bad;

            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                m_udp_hdr_valid <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= ST_FIRST;
                        busy  <= 1'b1;
                    end
                end
                ST_FIRST: begin
                    if (beat_xfer) begin
                        if (frame_start) begin
                            m_udp_hdr_valid <= 1'b1;
                        end
                        if (s_ip_payload.last) begin
                            state <= ST_IDLE;
                            busy  <= 1'b0;
                        end else if (first_bad) begin
                            state <= ST_DROP;
                        end else begin
                            state <= ST_FORWARD;
                        end
                    end
                end
                default: begin
                    // Forward or drop until the end of the frame
                    if (beat_xfer && s_ip_payload.last) begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            m_udp_hdr.ip <= s_ip_hdr;
        end
        if (frame_start) begin
            m_udp_hdr.udp <= first_word.hdr;
        end
    end

endmodule

// ==== rtl/udp_payload_trim.sv ====
// UDP payload trim stage
module udp_payload_trim (
    input  logic                                    clk,
    input  logic                                    reset,

    input  logic                                    frame_start,
    input  logic [net_hdr_pkg::UDP_FIELD_WIDTH-1:0] udp_length,
    input  logic                                    fwd_valid,
    input  udp_stream_pkg::axis_beat_t              fwd_beat,
    output logic                                    fwd_ready,

    output logic                                    m_udp_payload_valid,
    output udp_stream_pkg::axis_beat_t              m_udp_payload,
    input  logic                                    m_udp_payload_ready,

    output logic                                    error_payload_early_termination
);
    import net_hdr_pkg::*;
    import udp_stream_pkg::*;

    logic [UDP_FIELD_WIDTH-1:0] remaining;
    logic                       drop;
    logic [COUNT_WIDTH-1:0]     beat_bytes;
    logic [DATA_BYTES-1:0]      end_keep;
    logic                       in_xfer;
    logic                       reach_end;

    // Keep is contiguous, so a plain count gives the byte total
    always_comb begin
        beat_bytes = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            beat_bytes = beat_bytes + COUNT_WIDTH'(fwd_beat.keep[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < DATA_BYTES; i++) begin
            end_keep[i] = fwd_beat.keep[i] && (UDP_FIELD_WIDTH'(i) < remaining);
        end
    end

    assign reach_end = UDP_FIELD_WIDTH'(beat_bytes) >= remaining;
    assign fwd_ready = !m_udp_payload_valid || m_udp_payload_ready;
    assign in_xfer   = fwd_valid && fwd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            m_udp_payload_valid             <= 1'b0;
            remaining                       <= '0;
            drop                            <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            error_payload_early_termination <= 1'b0;

            if (m_udp_payload_valid && m_udp_payload_ready) begin
                m_udp_payload_valid <= 1'b0;
            end

            if (frame_start) begin
                remaining <= udp_length - UDP_FIELD_WIDTH'(UDP_HDR_BYTES);
                // Header-only frame, nothing of the payload is kept
                drop      <= udp_length <= UDP_FIELD_WIDTH'(UDP_HDR_BYTES);
            end else if (in_xfer) begin
                if (drop) begin
                    drop <= !fwd_beat.last;
                end else begin
                    m_udp_payload_valid <= 1'b1;
                    if (reach_end) begin
                        remaining <= '0;
                        drop      <= !fwd_beat.last;
                    end else begin
                        remaining <= remaining - UDP_FIELD_WIDTH'(beat_bytes);
                        if (fwd_beat.last) begin
                            error_payload_early_termination <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer && !drop) begin
            m_udp_payload.data <= fwd_beat.data;
            if (reach_end) begin
                m_udp_payload.keep <= end_keep;
                m_udp_payload.last <= 1'b1;
                m_udp_payload.user <= fwd_beat.user;
            end else begin
                m_udp_payload.keep <= fwd_beat.keep;
                m_udp_payload.last <= fwd_beat.last;
                // Input ended before the UDP length was reached
                m_udp_payload.user <= fwd_beat.user || fwd_beat.last;
            end
        end
    end

endmodule

// ==== rtl/udp_rx_64.sv ====
// UDP receive, 64-bit datapath
module udp_rx_64 (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       s_ip_hdr_valid,
    input  net_hdr_pkg::ip_hdr_t       s_ip_hdr,
    output logic                       s_ip_hdr_ready,
    input  logic                       s_ip_payload_valid,
    input  udp_stream_pkg::axis_beat_t s_ip_payload,
    output logic                       s_ip_payload_ready,

    output logic                       m_udp_hdr_valid,
    output net_hdr_pkg::udp_meta_t     m_udp_hdr,
    input  logic                       m_udp_hdr_ready,
    output logic                       m_udp_payload_valid,
    output udp_stream_pkg::axis_beat_t m_udp_payload,
    input  logic                       m_udp_payload_ready,

    output logic                       busy,
    output logic                       error_header_early_termination,
    output logic                       error_payload_early_termination
);
    import net_hdr_pkg::*;
    import udp_stream_pkg::*;

    // Between capture and trim
    logic                       frame_start;
    logic [UDP_FIELD_WIDTH-1:0] udp_length;
    logic                       fwd_valid;
    axis_beat_t                 fwd_beat;
    logic                       fwd_ready;

    udp_hdr_capture udp_hdr_capture_i (
        .clk                            (clk),
        .reset                          (reset),
        .s_ip_hdr_valid                 (s_ip_hdr_valid),
        .s_ip_hdr                       (s_ip_hdr),
        .s_ip_hdr_ready                 (s_ip_hdr_ready),
        .s_ip_payload_valid             (s_ip_payload_valid),
        .s_ip_payload                   (s_ip_payload),
        .s_ip_payload_ready             (s_ip_payload_ready),
        .m_udp_hdr_valid                (m_udp_hdr_valid),
        .m_udp_hdr                      (m_udp_hdr),
        .m_udp_hdr_ready                (m_udp_hdr_ready),
        .frame_start                    (frame_start),
        .udp_length                     (udp_length),
        .fwd_valid                      (fwd_valid),
        .fwd_beat                       (fwd_beat),
        .fwd_ready                      (fwd_ready),
        .busy                           (busy),
        .error_header_early_termination (error_header_early_termination)
    );

    udp_payload_trim udp_payload_trim_i (
        .clk                             (clk),
        .reset                           (reset),
        .frame_start                     (frame_start),
        .udp_length                      (udp_length),
        .fwd_valid                       (fwd_valid),
        .fwd_beat                        (fwd_beat),
        .fwd_ready                       (fwd_ready),
        .m_udp_payload_valid             (m_udp_payload_valid),
        .m_udp_payload                   (m_udp_payload),
        .m_udp_payload_ready             (m_udp_payload_ready),
        .error_payload_early_termination (error_payload_early_termination)
    );

endmodule

// ==== tb/udp_rx_64_assertions.sv ====
// UDP receive checker
module udp_rx_64_assertions (
    input logic                       clk,
    input logic                       reset,
    input logic                       s_ip_hdr_valid,
    input net_hdr_pkg::ip_hdr_t       s_ip_hdr,
    input logic                       s_ip_hdr_ready,
    input logic                       s_ip_payload_valid,
    input udp_stream_pkg::axis_beat_t s_ip_payload,
    input logic                       s_ip_payload_ready,
    input logic                       m_udp_hdr_valid,
    input net_hdr_pkg::udp_meta_t     m_udp_hdr,
    input logic                       m_udp_hdr_ready,
    input logic                       m_udp_payload_valid,
    input udp_stream_pkg::axis_beat_t m_udp_payload,
    input logic                       m_udp_payload_ready,
    input logic                       busy,
    input logic                       error_header_early_termination,
    input logic                       error_payload_early_termination
);
    import net_hdr_pkg::*;
    import udp_stream_pkg::*;

    int          fail_count = 0;
    logic        seen_hdr;
    logic        want_first;
    logic        exp_busy;
    logic        exp_hdr_valid;
    logic        exp_hdr_err;
    logic        exp_pay_err;
    udp_meta_t   exp_hdr;
    logic [15:0] exp_rem;
    logic        exp_drop;
    axis_beat_t  exp_mem [0:7];
    logic [2:0]  wr_ptr;
    logic [2:0]  rd_ptr;
    logic        pay_xfer;
    logic [15:0] first_len;
    logic [15:0] beat_bytes;
    axis_beat_t  out_beat;

    assign pay_xfer   = s_ip_payload_valid && s_ip_payload_ready;
    assign first_len  = {s_ip_payload.data[39:32], s_ip_payload.data[47:40]};
    assign beat_bytes = 16'($countones(s_ip_payload.keep));

    // Output beat expected for a payload beat that is not dropped
    always_comb begin
        out_beat = s_ip_payload;
        if (beat_bytes >= exp_rem) begin
            out_beat.keep = s_ip_payload.keep & ~(8'hff << exp_rem);
            out_beat.last = 1'b1;
        end else begin
            out_beat.user = s_ip_payload.user || s_ip_payload.last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            seen_hdr      <= 1'b0;
            want_first    <= 1'b0;
            exp_busy      <= 1'b0;
            exp_hdr_valid <= 1'b0;
            exp_hdr_err   <= 1'b0;
            exp_pay_err   <= 1'b0;
            exp_drop      <= 1'b0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
        end else begin
            exp_hdr_err <= 1'b0;
            exp_pay_err <= 1'b0;
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                exp_hdr_valid <= 1'b0;
            end
            if (m_udp_payload_valid && m_udp_payload_ready) begin
                rd_ptr <= rd_ptr + 3'd1;
            end
            if (s_ip_hdr_valid && s_ip_hdr_ready) begin
                seen_hdr   <= 1'b1;
                want_first <= 1'b1;
                exp_busy   <= 1'b1;
                exp_hdr.ip <= s_ip_hdr;
            end
            if (pay_xfer) begin
                want_first <= 1'b0;
                exp_busy   <= !s_ip_payload.last;
            end
            if (pay_xfer && want_first) begin
                if (s_ip_payload.last && s_ip_payload.keep != 8'hff) begin
                    exp_hdr_err <= 1'b1;
                end else begin
                    exp_hdr_valid <= 1'b1;
                    // Big-endian fields, wire byte 0 is the high byte of source_port
                    exp_hdr.udp   <= {s_ip_payload.data[7:0], s_ip_payload.data[15:8],
                                      s_ip_payload.data[23:16], s_ip_payload.data[31:24],
                                      first_len,
                                      s_ip_payload.data[55:48], s_ip_payload.data[63:56]};
                    exp_rem       <= first_len - 16'd8;
                    exp_drop      <= first_len == 16'd8;
                end
            end else if (pay_xfer && !exp_drop) begin
                exp_mem[wr_ptr] <= out_beat;
                wr_ptr          <= wr_ptr + 3'd1;
                if (beat_bytes >= exp_rem) begin
                    exp_drop <= 1'b1;
                end else begin
                    exp_rem     <= exp_rem - beat_bytes;
                    exp_pay_err <= s_ip_payload.last;
                end
            end
        end
    end

    quiet_before_first_hdr: assert property (@(posedge clk) disable iff (reset)
        !seen_hdr |-> !(m_udp_hdr_valid || m_udp_payload_valid || busy
            || error_header_early_termination || error_payload_early_termination))
        else begin
            $error("Error at %0t: output active before the first IP header", $time);
            fail_count++;
        end

    // Header valid, busy and both error pulses
    control_match: assert property (@(posedge clk) disable iff (reset)
        {m_udp_hdr_valid, busy, error_header_early_termination, error_payload_early_termination}
        == {exp_hdr_valid, exp_busy, exp_hdr_err, exp_pay_err})
        else begin
            $error("Error at %0t: control outputs differ from the expected values", $time);
            fail_count++;
        end

    // Inputs open when idle or when the output register has room
    ready_match: assert property (@(posedge clk) disable iff (reset)
        {s_ip_hdr_ready, s_ip_payload_ready}
        == {!exp_busy && !exp_hdr_valid,
            want_first || (exp_busy && (wr_ptr == rd_ptr || m_udp_payload_ready))})
        else begin
            $error("Error at %0t: input ready differs from the expected value", $time);
            fail_count++;
        end

    hdr_fields_match: assert property (@(posedge clk) disable iff (reset)
        m_udp_hdr_valid |-> m_udp_hdr == exp_hdr)
        else begin
            $error("Error at %0t: UDP frame header fields are wrong", $time);
            fail_count++;
        end

    // One expected beat pending exactly while the output register is full
    payload_count_match: assert property (@(posedge clk) disable iff (reset)
        m_udp_payload_valid == (wr_ptr != rd_ptr))
        else begin
            $error("Error at %0t: payload beat missing or unexpected", $time);
            fail_count++;
        end

    payload_beat_match: assert property (@(posedge clk) disable iff (reset)
        m_udp_payload_valid |-> m_udp_payload == exp_mem[rd_ptr])
        else begin
            $error("Error at %0t: payload data, keep, last or user is wrong", $time);
            fail_count++;
        end

endmodule

// ==== tb/tb_udp_rx_64.sv ====
// UDP receive testbench
module tb_udp_rx_64;
    import net_hdr_pkg::*;
    import udp_stream_pkg::*;

    localparam int FRAMES      = 30;
    localparam int CYCLE_LIMIT = 40 * 64;

    logic       clk = 1'b0;
    logic       reset;
    logic       s_ip_hdr_valid;
    ip_hdr_t    s_ip_hdr;
    logic       s_ip_hdr_ready;
    logic       s_ip_payload_valid;
    axis_beat_t s_ip_payload;
    logic       s_ip_payload_ready;
    logic       m_udp_hdr_valid;
    udp_meta_t  m_udp_hdr;
    logic       m_udp_hdr_ready;
    logic       m_udp_payload_valid;
    axis_beat_t m_udp_payload;
    logic       m_udp_payload_ready;
    logic       busy;
    logic       error_header_early_termination;
    logic       error_payload_early_termination;
    int         cycle_count = 0;
    string      class_names [0:5] = '{"exact", "trimmed", "short", "header only",
                                      "length 8 with extra beats", "header error"};

    udp_rx_64 udp_rx_64_i (.*);

    bind udp_rx_64 udp_rx_64_assertions checks_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run stalled after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Next clock, then new random back-pressure on both outputs
    task automatic step();
        @(posedge clk);
        #2;
        m_udp_hdr_ready     = ($urandom % 4) != 0;
        m_udp_payload_ready = ($urandom % 3) != 0;
    endtask

    task automatic wait_accept(input logic hdr);
        logic took;
        do begin
            @(negedge clk);
            took = hdr ? s_ip_hdr_ready : s_ip_payload_ready;
            step();
        end while (!took);
    endtask

    task automatic send_frame(input int kind);
        int           pay;
        int           len;
        logic [15:0]  udp_len;
        logic [287:0] bits;
        axis_beat_t   beat;
        // pay counts input bytes after the UDP header, len the UDP payload bytes
        case (kind)
            0: begin pay = 1 + $urandom % 40; len = pay; end
            1: begin pay = 2 + $urandom % 40; len = 1 + $urandom % (pay - 1); end
            2: begin pay = 1 + $urandom % 30; len = pay + 1 + $urandom % 20; end
            4: begin pay = 1 + $urandom % 24; len = 0; end
            default: begin pay = 0; len = 0; end
        endcase
        udp_len = 16'(len + 8);
        for (int i = 0; i < 9; i++) begin
            bits = {bits[255:0], $urandom};
        end
        s_ip_hdr       = bits[$bits(ip_hdr_t)-1:0];
        s_ip_hdr_valid = 1'b1;
        wait_accept(1'b1);
        s_ip_hdr_valid = 1'b0;
        beat.data         = {$urandom, $urandom};
        beat.data[47:32]  = {udp_len[7:0], udp_len[15:8]};
        beat.keep         = (kind == 5) ? (8'hff >> (1 + $urandom % 7)) : 8'hff;
        beat.last         = (pay == 0);
        beat.user         = 1'b0;
        s_ip_payload       = beat;
        s_ip_payload_valid = 1'b1;
        wait_accept(1'b0);
        for (int sent = 0; sent < pay; sent += 8) begin
            beat.data    = {$urandom, $urandom};
            beat.keep    = (pay - sent >= 8) ? 8'hff : (8'hff >> (8 - (pay - sent)));
            beat.last    = (pay - sent <= 8);
            s_ip_payload = beat;
            wait_accept(1'b0);
        end
        s_ip_payload_valid = 1'b0;
        while (busy || m_udp_hdr_valid || m_udp_payload_valid) begin
            step();
        end
    endtask

    initial begin
        int errors_before;
        int new_errors;
        int failed_frames;
        void'($urandom(32'h1fb09c03));
        reset               = 1'b1;
        s_ip_hdr_valid      = 1'b0;
        s_ip_hdr            = '0;
        s_ip_payload_valid  = 1'b0;
        s_ip_payload        = '0;
        m_udp_hdr_ready     = 1'b1;
        m_udp_payload_ready = 1'b1;
        failed_frames       = 0;
        repeat (5) step();
        reset = 1'b0;
        // A few idle cycles before the first header
        repeat (4) step();
        for (int n = 0; n < FRAMES; n++) begin
            errors_before = udp_rx_64_i.checks_i.fail_count;
            send_frame(n % 6);
            new_errors = udp_rx_64_i.checks_i.fail_count - errors_before;
            if (new_errors != 0) begin
                failed_frames++;
            end
            $display("Frame %0d, %s: %0d assertion failures", n, class_names[n % 6], new_errors);
        end
        $display("%0d frames, %0d with errors, %0d assertion failures in total",
                 FRAMES, failed_frames, udp_rx_64_i.checks_i.fail_count);
        if (udp_rx_64_i.checks_i.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/net_hdr_pkg.sv
rtl/udp_stream_pkg.sv
rtl/udp_hdr_capture.sv
rtl/udp_payload_trim.sv
rtl/udp_rx_64.sv
tb/udp_rx_64_assertions.sv
tb/tb_udp_rx_64.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UDP receive testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_udp_rx_64 \
    -f files.f --Mdir obj_dir -o tb_udp_rx_64
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_udp_rx_64 +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$log"; then
    exit 1
fi
if ! grep -q "TEST OK" "$log"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
